//--- csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  csr_cmd_t;
    typedef logic [1:0]  priv_mode_t;

    // Command codes as issued by decode
    localparam csr_cmd_t CSR_X     = 3'd0;
    localparam csr_cmd_t CSR_W     = 3'd1;
    localparam csr_cmd_t CSR_S     = 3'd2;
    localparam csr_cmd_t CSR_C     = 3'd3;
    localparam csr_cmd_t CSR_ECALL = 3'd4;
    localparam csr_cmd_t CSR_MRET  = 3'd5;
    localparam csr_cmd_t CSR_SRET  = 3'd6;

    localparam priv_mode_t MODE_USER       = 2'b00;
    localparam priv_mode_t MODE_SUPERVISOR = 2'b01;
    localparam priv_mode_t MODE_MACHINE    = 2'b11;

    // Counters, read only
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_ADDR_TIME     = 12'hc01;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t CSR_ADDR_TIMEH    = 12'hc81;

    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t CSR_ADDR_MIDELEG  = 12'h303;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;

    localparam csr_addr_t CSR_ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t CSR_ADDR_SIE      = 12'h104;
    localparam csr_addr_t CSR_ADDR_STVEC    = 12'h105;
    localparam csr_addr_t CSR_ADDR_SEPC     = 12'h141;
    localparam csr_addr_t CSR_ADDR_SCAUSE   = 12'h142;

    // Squashed requests point here and read zero
    localparam csr_addr_t CSR_ADDR_NONE     = 12'hfff;

    localparam word_t MCAUSE_M_TIMER    = 32'h8000_0080;
    localparam word_t SCAUSE_S_TIMER    = 32'h8000_0020;
    localparam word_t MCAUSE_ECALL_BASE = 32'd8;

    localparam word_t SSTATUS_MASK = 32'h800d_e762;
    localparam word_t SIE_MASK     = 32'h0000_0222;
    localparam word_t MIE_MASK     = 32'h0000_0aaa;

    localparam int MIDELEG_MTIE_BIT = 7;

    typedef struct packed {
        csr_cmd_t cmd;
        word_t    op1;
        word_t    imm_i;
    } csr_req_t;

    typedef struct packed {
        logic       sd;
        logic [7:0] wpri_23;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        priv_mode_t mpp;
        logic [1:0] vs;
        logic       spp;
        logic       mpie;
        logic       ube;
        logic       spie;
        logic       wpri_4;
        logic       mie;
        logic       wpri_2;
        logic       sie;
        logic       wpri_0;
    } mstatus_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_M_TIMER,
        TRAP_S_TIMER,
        TRAP_ECALL,
        TRAP_MRET
    } trap_kind_t;

    typedef struct packed {
        trap_kind_t kind;
        priv_mode_t prior_mode;
        word_t      epc;
    } trap_event_t;

    typedef struct packed {
        mstatus_t mstatus;
        word_t    medeleg;
        logic     mideleg_mtie;
        word_t    mie;
        word_t    mtvec;
        word_t    mscratch;
        word_t    mepc;
        word_t    mcause;
        word_t    mtval;
        word_t    mip;
        word_t    stvec;
        word_t    sepc;
        word_t    scause;
    } csr_state_t;

endpackage

`default_nettype wire

//--- csr_trap_ctrl.sv
`default_nettype none

module csr_trap_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,
    input  csr_pkg::csr_cmd_t    cmd,
    input  csr_pkg::dword_t      mtime,
    input  csr_pkg::dword_t      mtimecmp,
    input  logic                 interrupt_ready,
    input  csr_pkg::word_t       if_pc,
    input  csr_pkg::csr_state_t  state,
    output csr_pkg::csr_cmd_t    exec_cmd,
    output csr_pkg::word_t       trap_vector,
    output logic                 interrupt_stall,
    output csr_pkg::trap_event_t trap
);

    import csr_pkg::*;

    priv_mode_t mode_q;
    logic       timer_due;
    logic       m_timer_enabled;
    logic       s_timer_enabled;
    logic       take_interrupt;
    logic       to_supervisor;

    assign timer_due = mtime >= mtimecmp;

    // mie bit 7 is mtie, bit 5 is stie
    assign m_timer_enabled = (mode_q == MODE_MACHINE) && state.mie[7]
                             && !state.mideleg_mtie && state.mstatus.mie;
    assign s_timer_enabled = (mode_q == MODE_SUPERVISOR) && state.mie[5]
                             && state.mstatus.sie;

    assign interrupt_stall = timer_due && (m_timer_enabled || s_timer_enabled);
    assign take_interrupt  = interrupt_stall && interrupt_ready;

    // Only delegated and taken below M does the timer land in S
    assign to_supervisor = (mode_q != MODE_MACHINE) && state.mideleg_mtie;

    always_comb begin
        trap.kind       = TRAP_NONE;
        trap.prior_mode = mode_q;
        trap.epc        = if_pc;
        if (take_interrupt) begin
            trap.kind = to_supervisor ? TRAP_S_TIMER : TRAP_M_TIMER;
        end else if (cmd == CSR_ECALL) begin
            trap.kind = TRAP_ECALL;
        end else if (cmd == CSR_MRET) begin
            trap.kind = TRAP_MRET;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q      <= MODE_MACHINE;
            exec_cmd    <= CSR_X;
            trap_vector <= '0;
        end else begin
            // An interrupt shows up downstream as an ECALL
            exec_cmd <= take_interrupt ? CSR_ECALL : cmd;
            case (trap.kind)
                TRAP_M_TIMER, TRAP_ECALL: begin
                    mode_q      <= MODE_MACHINE;
                    trap_vector <= state.mtvec;
                end
                TRAP_S_TIMER: begin
                    mode_q      <= MODE_SUPERVISOR;
                    trap_vector <= state.stvec;
                end
                TRAP_MRET: begin
                    mode_q      <= state.mstatus.mpp;
                    trap_vector <= state.mepc;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- csr_regfile.sv
`default_nettype none

module csr_regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  csr_pkg::trap_event_t trap,
    input  csr_pkg::csr_write_t  wr,
    output csr_pkg::csr_state_t  state
);

    import csr_pkg::*;

    csr_state_t state_q;
    word_t      mstatus_word;

    assign state        = state_q;
    assign mstatus_word = word_t'(state_q.mstatus);

    // Reserved mstatus fields stay zero whatever is written
    function automatic mstatus_t mstatus_clean(word_t w);
        mstatus_t m;
        m         = mstatus_t'(w);
        m.wpri_23 = '0;
        m.wpri_4  = 1'b0;
        m.wpri_2  = 1'b0;
        m.wpri_0  = 1'b0;
        return m;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q             <= '0;
            state_q.mstatus.mpp <= MODE_MACHINE;
        end else begin
            case (trap.kind)
                TRAP_M_TIMER: begin
                    state_q.mstatus.mpp  <= trap.prior_mode;
                    state_q.mstatus.mpie <= state_q.mstatus.mie;
                    state_q.mstatus.mie  <= 1'b0;
                    state_q.mepc         <= trap.epc;
                    state_q.mcause       <= MCAUSE_M_TIMER;
                end
                TRAP_S_TIMER: begin
                    state_q.mstatus.spp  <= trap.prior_mode[0];
                    state_q.mstatus.spie <= state_q.mstatus.sie;
                    state_q.mstatus.sie  <= 1'b0;
                    state_q.sepc         <= trap.epc;
                    state_q.scause       <= SCAUSE_S_TIMER;
                end
                TRAP_ECALL: begin
                    // 8 for U, 9 for S, 11 for M
                    state_q.mcause <= MCAUSE_ECALL_BASE + word_t'(trap.prior_mode);
                end
                TRAP_MRET: begin
                    state_q.mstatus.mie <= state_q.mstatus.mpie;
                    state_q.mstatus.mpp <= MODE_USER;
                    if (state_q.mstatus.mpp != MODE_MACHINE) begin
                        state_q.mstatus.mprv <= 1'b0;
                    end
                end
                default: begin
                end
            endcase

            // Later assignments win over the trap update above
            if (wr.en) begin
                case (wr.addr)
                    CSR_ADDR_MSTATUS:  state_q.mstatus  <= mstatus_clean(wr.data);
                    CSR_ADDR_MEDELEG:  state_q.medeleg  <= wr.data;
                    CSR_ADDR_MIDELEG:  state_q.mideleg_mtie <= wr.data[MIDELEG_MTIE_BIT];
                    CSR_ADDR_MIE:      state_q.mie      <= wr.data & MIE_MASK;
                    CSR_ADDR_MTVEC:    state_q.mtvec    <= wr.data;
                    CSR_ADDR_MSCRATCH: state_q.mscratch <= wr.data;
                    CSR_ADDR_MEPC:     state_q.mepc     <= wr.data;
                    CSR_ADDR_MCAUSE:   state_q.mcause   <= wr.data;
                    CSR_ADDR_MTVAL:    state_q.mtval    <= wr.data;
                    CSR_ADDR_MIP:      state_q.mip      <= wr.data;
                    CSR_ADDR_STVEC:    state_q.stvec    <= wr.data;
                    CSR_ADDR_SEPC:     state_q.sepc     <= wr.data;
                    CSR_ADDR_SCAUSE:   state_q.scause   <= wr.data;
                    CSR_ADDR_SSTATUS: begin
                        // S view only reaches the sstatus bits
                        state_q.mstatus <= mstatus_t'((mstatus_word & ~SSTATUS_MASK)
                                                      | (wr.data & SSTATUS_MASK));
                    end
                    CSR_ADDR_SIE: begin
                        state_q.mie <= (state_q.mie & ~SIE_MASK) | (wr.data & SIE_MASK);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- csr_read_mux.sv
`default_nettype none

module csr_read_mux (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_addr_t  addr,
    input  csr_pkg::csr_state_t state,
    input  csr_pkg::dword_t     cycle,
    input  csr_pkg::dword_t     time_count,
    output csr_pkg::word_t      rdata
);

    import csr_pkg::*;

    word_t rdata_d;
    word_t mstatus_word;

    assign mstatus_word = word_t'(state.mstatus);

    always_comb begin
        case (addr)
            CSR_ADDR_CYCLE:    rdata_d = cycle[31:0];
            CSR_ADDR_TIME:     rdata_d = time_count[31:0];
            CSR_ADDR_CYCLEH:   rdata_d = cycle[63:32];
            CSR_ADDR_TIMEH:    rdata_d = time_count[63:32];
            CSR_ADDR_MSTATUS:  rdata_d = mstatus_word;
            CSR_ADDR_MEDELEG:  rdata_d = state.medeleg;
            // Only the timer bit is implemented
            CSR_ADDR_MIDELEG:  rdata_d = word_t'(state.mideleg_mtie) << MIDELEG_MTIE_BIT;
            CSR_ADDR_MIE:      rdata_d = state.mie;
            CSR_ADDR_MTVEC:    rdata_d = state.mtvec;
            CSR_ADDR_MSCRATCH: rdata_d = state.mscratch;
            CSR_ADDR_MEPC:     rdata_d = state.mepc;
            CSR_ADDR_MCAUSE:   rdata_d = state.mcause;
            CSR_ADDR_MTVAL:    rdata_d = state.mtval;
            CSR_ADDR_MIP:      rdata_d = state.mip;
            // S views of the machine registers
            CSR_ADDR_SSTATUS:  rdata_d = mstatus_word & SSTATUS_MASK;
            CSR_ADDR_SIE:      rdata_d = state.mie & SIE_MASK;
            CSR_ADDR_STVEC:    rdata_d = state.stvec;
            CSR_ADDR_SEPC:     rdata_d = state.sepc;
            CSR_ADDR_SCAUSE:   rdata_d = state.scause;
            default:           rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rdata_d;
        end
    end

endmodule

`default_nettype wire

//--- csr_write_stage.sv
`default_nettype none

module csr_write_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_cmd_t   cmd,
    input  csr_pkg::csr_addr_t  addr,
    input  csr_pkg::word_t      op1,
    input  csr_pkg::word_t      rdata,
    output csr_pkg::csr_write_t wr
);

    import csr_pkg::*;

    csr_cmd_t  cmd_q;
    csr_addr_t addr_q;
    word_t     op1_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q <= CSR_X;
        end else begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;
        op1_q  <= op1;
    end

    // rdata is the registered read of the same address one cycle back
    always_comb begin
        wr.en   = 1'b0;
        wr.addr = addr_q;
        wr.data = '0;
        case (cmd_q)
            CSR_W: begin
                wr.en   = 1'b1;
                wr.data = op1_q;
            end
            CSR_S: begin
                wr.en   = 1'b1;
                wr.data = rdata | op1_q;
            end
            CSR_C: begin
                wr.en   = 1'b1;
                wr.data = rdata & ~op1_q;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- csr_stage.sv
`default_nettype none

module csr_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  csr_pkg::dword_t   cycle,
    input  csr_pkg::dword_t   time_count,
    input  csr_pkg::dword_t   mtime,
    input  csr_pkg::dword_t   mtimecmp,
    input  logic              wb_branch_hazard,
    input  csr_pkg::csr_req_t req,
    input  logic              interrupt_ready,
    input  csr_pkg::word_t    if_pc,
    output csr_pkg::csr_cmd_t exec_cmd,
    output csr_pkg::word_t    rdata,
    output csr_pkg::word_t    trap_vector,
    output logic              interrupt_stall
);

    import csr_pkg::*;

    csr_cmd_t    cmd_eff;
    csr_addr_t   addr_eff;
    csr_state_t  state;
    trap_event_t trap;
    csr_write_t  wr;

    // A branch hazard in writeback turns the request into a no-op read of nothing
    assign cmd_eff  = wb_branch_hazard ? CSR_X : req.cmd;
    assign addr_eff = wb_branch_hazard ? CSR_ADDR_NONE : req.imm_i[11:0];

    csr_trap_ctrl trap_ctrl_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd             (cmd_eff),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .interrupt_ready (interrupt_ready),
        .if_pc           (if_pc),
        .state           (state),
        .exec_cmd        (exec_cmd),
        .trap_vector     (trap_vector),
        .interrupt_stall (interrupt_stall),
        .trap            (trap)
    );

    csr_regfile regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .trap   (trap),
        .wr     (wr),
        .state  (state)
    );

    csr_read_mux read_mux_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (addr_eff),
        .state      (state),
        .cycle      (cycle),
        .time_count (time_count),
        .rdata      (rdata)
    );

    csr_write_stage write_stage_i (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (cmd_eff),
        .addr   (addr_eff),
        .op1    (req.op1),
        .rdata  (rdata),
        .wr     (wr)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_csr_stage.sv
`default_nettype none

module tb_csr_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    // The tests need well under 200 cycles including reset
    localparam int        TEST_CYCLES     = 200;
    localparam int        TIMEOUT_CYCLES  = 10 * TEST_CYCLES;
    localparam dword_t    MTIMECMP_VAL    = 64'h0000_0001_0000_0000;
    // Reserved mstatus bits 30:23, 4, 2 and 0
    localparam word_t     MSTATUS_WPRI    = 32'h7f80_0015;
    localparam csr_addr_t CSR_ADDR_UNUSED = 12'h7c0;

    logic     clk;
    logic     arst_n;
    dword_t   cycle;
    dword_t   time_count;
    dword_t   mtime;
    dword_t   mtimecmp;
    logic     wb_branch_hazard;
    csr_req_t req;
    logic     interrupt_ready;
    word_t    if_pc;
    csr_cmd_t exec_cmd;
    word_t    rdata;
    word_t    trap_vector;
    logic     interrupt_stall;

    // Driven with the next request
    logic     hazard_v;
    logic     ready_v;
    logic     take_v;
    logic     stall_v;
    word_t    pc_v;
    dword_t   mtime_v;
    word_t    tvec_m;

    // Expected outputs in the current cycle and after the next edge
    word_t    exp_rdata;
    word_t    nxt_rdata;
    csr_cmd_t exp_cmd;
    csr_cmd_t nxt_cmd;
    word_t    exp_tvec;
    word_t    nxt_tvec;
    logic     exp_stall;
    logic     checking;

    // Reference copies of the CSRs
    word_t    mscratch_m;
    word_t    mstatus_m;
    word_t    mie_m;
    word_t    mtvec_m;
    word_t    mepc_m;
    word_t    stvec_m;

    word_t    rng;
    int       errors;
    int       checks;
    int       cycle_count;

    tb_clock_gen clock_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    csr_stage dut_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .cycle            (cycle),
        .time_count       (time_count),
        .mtime            (mtime),
        .mtimecmp         (mtimecmp),
        .wb_branch_hazard (wb_branch_hazard),
        .req              (req),
        .interrupt_ready  (interrupt_ready),
        .if_pc            (if_pc),
        .exec_cmd         (exec_cmd),
        .rdata            (rdata),
        .trap_vector      (trap_vector),
        .interrupt_stall  (interrupt_stall)
    );

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One request per cycle, expectations shifted one cycle ahead
    task automatic issue(input csr_cmd_t cmd, input csr_addr_t addr, input word_t op1,
                         input word_t rexp);
        csr_req_t r;
        r.cmd   = cmd;
        r.op1   = op1;
        r.imm_i = {20'h0, addr};
        @(posedge clk);
        req              <= r;
        wb_branch_hazard <= hazard_v;
        interrupt_ready  <= ready_v;
        if_pc            <= pc_v;
        mtime            <= mtime_v;
        exp_rdata = nxt_rdata;
        exp_cmd   = nxt_cmd;
        exp_tvec  = nxt_tvec;
        exp_stall = stall_v;
        checking  = 1'b1;
        nxt_rdata = rexp;
        nxt_cmd   = take_v ? CSR_ECALL : (hazard_v ? CSR_X : cmd);
        nxt_tvec  = tvec_m;
    endtask

    task automatic idle_cycle();
        issue(CSR_X, CSR_ADDR_NONE, 32'h0, 32'h0);
    endtask

    // The idle cycle lets the write land before the next read
    task automatic write_csr(input csr_cmd_t cmd, input csr_addr_t addr, input word_t op1,
                             input word_t old);
        issue(cmd, addr, op1, old);
        idle_cycle();
    endtask

    task automatic expect_csr(input csr_addr_t addr, input word_t value);
        issue(CSR_X, addr, 32'h0, value);
    endtask

    // Raise the timer, then take it with interrupt_ready one cycle later
    task automatic take_timer_irq(input word_t vector);
        mtime_v = MTIMECMP_VAL;
        stall_v = 1'b1;
        idle_cycle();
        rng     = xorshift32(rng);
        pc_v    = rng;
        ready_v = 1'b1;
        take_v  = 1'b1;
        tvec_m  = vector;
        idle_cycle();
        ready_v = 1'b0;
        take_v  = 1'b0;
        stall_v = 1'b0;
        mtime_v = '0;
        idle_cycle();
    endtask

    always @(negedge clk) begin
        if (arst_n && checking) begin
            checks = checks + 4;
            assert (rdata === exp_rdata) else begin
                errors++;
                $display("CHECK FAILED rdata: got %h, expected %h", rdata, exp_rdata);
            end
            assert (exec_cmd === exp_cmd) else begin
                errors++;
                $display("CHECK FAILED exec_cmd: got %h, expected %h", exec_cmd, exp_cmd);
            end
            assert (trap_vector === exp_tvec) else begin
                errors++;
                $display("CHECK FAILED trap_vector: got %h, expected %h", trap_vector, exp_tvec);
            end
            assert (interrupt_stall === exp_stall) else begin
                errors++;
                $display("CHECK FAILED interrupt_stall: got %h, expected %h",
                         interrupt_stall, exp_stall);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rng              = 32'd79;
        req              = '0;
        wb_branch_hazard = 1'b0;
        interrupt_ready  = 1'b0;
        if_pc            = '0;
        mtime            = '0;
        mtimecmp         = MTIMECMP_VAL;
        rng              = xorshift32(rng);
        cycle[31:0]      = rng;
        rng              = xorshift32(rng);
        cycle[63:32]     = rng;
        rng              = xorshift32(rng);
        time_count[31:0] = rng;
        rng              = xorshift32(rng);
        time_count[63:32] = rng;
        hazard_v  = 1'b0;
        ready_v   = 1'b0;
        take_v    = 1'b0;
        stall_v   = 1'b0;
        pc_v      = '0;
        mtime_v   = '0;
        tvec_m    = '0;
        exp_rdata = '0;
        nxt_rdata = '0;
        exp_cmd   = CSR_X;
        nxt_cmd   = CSR_X;
        exp_tvec  = '0;
        nxt_tvec  = '0;
        exp_stall = 1'b0;
        checking  = 1'b0;
        errors    = 0;
        checks    = 0;
        mscratch_m = '0;
        mstatus_m  = 32'h0000_1800;
        mie_m      = '0;
        mtvec_m    = '0;
        mepc_m     = '0;
        stvec_m    = '0;
        wait (arst_n === 1'b1);

        // Reset state, then write, set and clear of mscratch
        expect_csr(CSR_ADDR_MSTATUS, mstatus_m);
        rng = xorshift32(rng);
        write_csr(CSR_W, CSR_ADDR_MSCRATCH, rng, mscratch_m);
        mscratch_m = rng;
        expect_csr(CSR_ADDR_MSCRATCH, mscratch_m);
        rng = xorshift32(rng);
        write_csr(CSR_S, CSR_ADDR_MSCRATCH, rng, mscratch_m);
        mscratch_m = mscratch_m | rng;
        expect_csr(CSR_ADDR_MSCRATCH, mscratch_m);
        rng = xorshift32(rng);
        write_csr(CSR_C, CSR_ADDR_MSCRATCH, rng, mscratch_m);
        mscratch_m = mscratch_m & ~rng;
        expect_csr(CSR_ADDR_MSCRATCH, mscratch_m);
        expect_csr(CSR_ADDR_UNUSED, 32'h0);
        expect_csr(CSR_ADDR_CYCLE, cycle[31:0]);
        expect_csr(CSR_ADDR_CYCLEH, cycle[63:32]);
        expect_csr(CSR_ADDR_TIME, time_count[31:0]);
        expect_csr(CSR_ADDR_TIMEH, time_count[63:32]);

        // S views of mstatus and mie
        rng = xorshift32(rng);
        write_csr(CSR_W, CSR_ADDR_MSTATUS, rng, mstatus_m);
        mstatus_m = rng & ~MSTATUS_WPRI;
        expect_csr(CSR_ADDR_MSTATUS, mstatus_m);
        expect_csr(CSR_ADDR_SSTATUS, mstatus_m & SSTATUS_MASK);
        rng = xorshift32(rng);
        write_csr(CSR_W, CSR_ADDR_MIE, rng, mie_m);
        mie_m = rng & MIE_MASK;
        expect_csr(CSR_ADDR_MIE, mie_m);
        expect_csr(CSR_ADDR_SIE, mie_m & SIE_MASK);
        rng = xorshift32(rng);
        // Opposite mpp bits, so a leak through the view would show
        rng[12:11] = ~mstatus_m[12:11];
        write_csr(CSR_W, CSR_ADDR_SSTATUS, rng, mstatus_m & SSTATUS_MASK);
        mstatus_m = (mstatus_m & ~SSTATUS_MASK) | (rng & SSTATUS_MASK);
        expect_csr(CSR_ADDR_MSTATUS, mstatus_m);

        // Machine timer interrupt taken in M
        rng = xorshift32(rng);
        write_csr(CSR_W, CSR_ADDR_MTVEC, rng, mtvec_m);
        mtvec_m = rng;
        write_csr(CSR_W, CSR_ADDR_MIE, 32'h0000_0080, mie_m);
        mie_m = 32'h0000_0080;
        write_csr(CSR_W, CSR_ADDR_MSTATUS, 32'h0000_1808, mstatus_m);
        mstatus_m = 32'h0000_1808;
        take_timer_irq(mtvec_m);
        mepc_m = pc_v;
        expect_csr(CSR_ADDR_MCAUSE, MCAUSE_M_TIMER);
        expect_csr(CSR_ADDR_MEPC, mepc_m);
        mstatus_m = 32'h0000_1880;
        expect_csr(CSR_ADDR_MSTATUS, mstatus_m);

        // MRET into S with mprv set, then ECALL from S
        write_csr(CSR_W, CSR_ADDR_MSTATUS, 32'h0002_0880, mstatus_m);
        tvec_m = mepc_m;
        issue(CSR_MRET, CSR_ADDR_NONE, 32'h0, 32'h0);
        mstatus_m = 32'h0000_0088;
        expect_csr(CSR_ADDR_MSTATUS, mstatus_m);
        tvec_m = mtvec_m;
        issue(CSR_ECALL, CSR_ADDR_NONE, 32'h0, 32'h0);
        expect_csr(CSR_ADDR_MCAUSE, 32'd9);
        write_csr(CSR_W, CSR_ADDR_MSTATUS, 32'h0000_0800, mstatus_m);
        tvec_m = mepc_m;
        issue(CSR_MRET, CSR_ADDR_NONE, 32'h0, 32'h0);
        mstatus_m = 32'h0;
        expect_csr(CSR_ADDR_MSTATUS, mstatus_m);

        // Timer delegated to S
        rng = xorshift32(rng);
        write_csr(CSR_W, CSR_ADDR_STVEC, rng, stvec_m);
        stvec_m = rng;
        write_csr(CSR_W, CSR_ADDR_MIDELEG, 32'hffff_ffff, 32'h0);
        expect_csr(CSR_ADDR_MIDELEG, 32'h0000_0080);
        write_csr(CSR_W, CSR_ADDR_MIE, 32'h0000_0020, mie_m);
        mie_m = 32'h0000_0020;
        write_csr(CSR_W, CSR_ADDR_SSTATUS, 32'h0000_0002, mstatus_m & SSTATUS_MASK);
        mstatus_m = 32'h0000_0002;
        take_timer_irq(stvec_m);
        expect_csr(CSR_ADDR_SEPC, pc_v);
        expect_csr(CSR_ADDR_SCAUSE, SCAUSE_S_TIMER);
        mstatus_m = 32'h0000_0120;
        expect_csr(CSR_ADDR_SSTATUS, mstatus_m & SSTATUS_MASK);

        // Squashed write leaves mscratch alone
        hazard_v = 1'b1;
        rng = xorshift32(rng);
        issue(CSR_W, CSR_ADDR_MSCRATCH, rng, 32'h0);
        hazard_v = 1'b0;
        idle_cycle();
        expect_csr(CSR_ADDR_MSCRATCH, mscratch_m);
        idle_cycle();
        @(posedge clk);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
csr_pkg.sv
csr_trap_ctrl.sv
csr_regfile.sv
csr_read_mux.sv
csr_write_stage.sv
csr_stage.sv
tb_clock_gen.sv
tb_csr_stage.sv
